// ==== hw/cpu_pkg.sv ====
package cpu_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] addr_t;
  typedef logic [2:0]  cycle_count_t;

  localparam int MAX_CYCLES_PER_INSTR = 5;

  typedef enum logic [1:0] {T1, T2, T3, T4} t_phase_t;

  typedef enum logic [3:0] {
    ADDR_NONE, ADDR_PC, ADDR_SP, ADDR_BC, ADDR_DE, ADDR_HL, ADDR_WZ, ADDR_FF_C, ADDR_FF_Z
  } addr_src_t;

  typedef enum logic [1:0] {BUS_NONE, BUS_READ, BUS_WRITE} bus_op_t;

  typedef enum logic [3:0] {
    REG_NONE, REG_A, REG_F, REG_B, REG_C, REG_D, REG_E, REG_H, REG_L, REG_W, REG_Z, REG_IR
  } reg_sel_t;

  typedef enum logic [1:0] {IDU_NONE, IDU_INC, IDU_DEC} idu_op_t;

  typedef enum logic [2:0] {ALU_NONE, ALU_ADD, ALU_SUB, ALU_XOR, ALU_MOV} alu_op_t;

  typedef enum logic [1:0] {MISC_NONE, MISC_COND_CHECK, MISC_JP_WZ, MISC_JR_Z} misc_op_t;

  typedef enum logic [1:0] {COND_NZ, COND_Z, COND_NC, COND_C} cond_t;

  // One machine cycle of an instruction
  typedef struct packed {
    addr_src_t addr_src;
    bus_op_t   bus_op;
    reg_sel_t  bus_reg;
    idu_op_t   idu_op;
    addr_src_t idu_dst;
    alu_op_t   alu_op;
    reg_sel_t  alu_dst;
    reg_sel_t  alu_src;
    misc_op_t  misc_op;
    cond_t     cond;
  } cycle_word_t;

  typedef struct packed {
    cycle_count_t                                num_cycles;
    cycle_word_t [MAX_CYCLES_PER_INSTR-1:0] cycles;
  } control_word_t;

  typedef struct packed {
    byte_t a;
    byte_t flags;
    byte_t b;
    byte_t c;
    byte_t d;
    byte_t e;
    byte_t h;
    byte_t l;
    byte_t w;
    byte_t z;
    byte_t sph;
    byte_t spl;
    byte_t pch;
    byte_t pcl;
    byte_t ir;
  } cpu_regs_t;

  // Bus load lands at the end of T3, everything else on the T4 strobe
  typedef struct packed {
    reg_sel_t   bus_reg;
    byte_t      bus_data;
    addr_src_t  idu_src;
    addr_src_t  idu_dst;
    idu_op_t    idu_op;
    reg_sel_t   alu_reg;
    byte_t      alu_data;
    logic [3:0] alu_flags;
    logic       pc_load;
    addr_t      pc_value;
    logic       t4;
  } reg_write_t;

  // Flags nibble is Z N H C
  typedef struct packed {
    byte_t      data;
    logic [3:0] flags;
  } alu_out_t;

  // Opcode fetch at PC into IR, overlapped with the last cycle of every instruction
  function automatic cycle_word_t fetch_cycle();
    cycle_word_t c;
    c = '0;
    c.addr_src = ADDR_PC;
    c.bus_op   = BUS_READ;
    c.bus_reg  = REG_IR;
    c.idu_op   = IDU_INC;
    return c;
  endfunction

  function automatic control_word_t nop_word();
    control_word_t w;
    w = '0;
    w.num_cycles = 3'd1;
    w.cycles[0] = fetch_cycle();
    return w;
  endfunction

  function automatic byte_t get_byte(cpu_regs_t r, reg_sel_t sel);
    case (sel)
      REG_A:   return r.a;
      REG_F:   return r.flags;
      REG_B:   return r.b;
      REG_C:   return r.c;
      REG_D:   return r.d;
      REG_E:   return r.e;
      REG_H:   return r.h;
      REG_L:   return r.l;
      REG_W:   return r.w;
      REG_Z:   return r.z;
      REG_IR:  return r.ir;
      default: return 8'h00;
    endcase
  endfunction

  function automatic addr_t get_pair(cpu_regs_t r, addr_src_t sel);
    case (sel)
      ADDR_PC:   return {r.pch, r.pcl};
      ADDR_SP:   return {r.sph, r.spl};
      ADDR_BC:   return {r.b, r.c};
      ADDR_DE:   return {r.d, r.e};
      ADDR_HL:   return {r.h, r.l};
      ADDR_WZ:   return {r.w, r.z};
      ADDR_FF_C: return {8'hff, r.c};
      ADDR_FF_Z: return {8'hff, r.z};
      default:   return 16'h0000;
    endcase
  endfunction

endpackage

// ==== hw/cpu_microcode.sv ====
`timescale 1ns/100ps

module cpu_microcode
  import cpu_pkg::*;
(
  input  byte_t         opcode,
  output control_word_t word
);

  // Immediate operand from the instruction stream, PC advances
  function automatic cycle_word_t imm_cycle(reg_sel_t dst);
    cycle_word_t c;
    c = '0;
    c.addr_src = ADDR_PC;
    c.bus_op   = BUS_READ;
    c.bus_reg  = dst;
    c.idu_op   = IDU_INC;
    return c;
  endfunction

  function automatic cycle_word_t mem_cycle(addr_src_t src, bus_op_t op, reg_sel_t r);
    cycle_word_t c;
    c = '0;
    c.addr_src = src;
    c.bus_op   = op;
    c.bus_reg  = r;
    return c;
  endfunction

  // ALU work rides along with the opcode fetch
  function automatic cycle_word_t alu_fetch(alu_op_t op, reg_sel_t dst, reg_sel_t src);
    cycle_word_t c;
    c = fetch_cycle();
    c.alu_op  = op;
    c.alu_dst = dst;
    c.alu_src = src;
    return c;
  endfunction

  function automatic cycle_word_t misc_cycle(misc_op_t op);
    cycle_word_t c;
    c = '0;
    c.misc_op = op;
    return c;
  endfunction

  // Register field in bits 5:3 of LD r,d8
  function automatic reg_sel_t ld_dst(logic [2:0] code);
    case (code)
      3'd0:    return REG_B;
      3'd1:    return REG_C;
      3'd2:    return REG_D;
      3'd3:    return REG_E;
      3'd4:    return REG_H;
      3'd5:    return REG_L;
      default: return REG_A;
    endcase
  endfunction

  always_comb begin
    word = nop_word();
    case (opcode)
      8'h06, 8'h0e, 8'h26, 8'h2e, 8'h3e: begin
        word.num_cycles = 3'd2;
        word.cycles[0]  = imm_cycle(REG_Z);
        word.cycles[1]  = alu_fetch(ALU_MOV, ld_dst(opcode[5:3]), REG_Z);
      end
      8'h77: begin
        word.num_cycles = 3'd2;
        word.cycles[0]  = mem_cycle(ADDR_HL, BUS_WRITE, REG_A);
        word.cycles[1]  = fetch_cycle();
      end
      8'h22: begin
        word.num_cycles       = 3'd2;
        word.cycles[0]        = mem_cycle(ADDR_HL, BUS_WRITE, REG_A);
        word.cycles[0].idu_op = IDU_INC;
        word.cycles[1]        = fetch_cycle();
      end
      8'h7e: begin
        word.num_cycles = 3'd2;
        word.cycles[0]  = mem_cycle(ADDR_HL, BUS_READ, REG_Z);
        word.cycles[1]  = alu_fetch(ALU_MOV, REG_A, REG_Z);
      end
      8'h80: word.cycles[0] = alu_fetch(ALU_ADD, REG_A, REG_B);
      8'h90: word.cycles[0] = alu_fetch(ALU_SUB, REG_A, REG_B);
      8'haf: word.cycles[0] = alu_fetch(ALU_XOR, REG_A, REG_A);
      8'h23: begin
        // Address is only the IDU source here, no strobe goes out
        word.num_cycles       = 3'd2;
        word.cycles[0]        = mem_cycle(ADDR_HL, BUS_NONE, REG_NONE);
        word.cycles[0].idu_op = IDU_INC;
        word.cycles[1]        = fetch_cycle();
      end
      8'hc3: begin
        word.num_cycles = 3'd4;
        word.cycles[0]  = imm_cycle(REG_Z);
        word.cycles[1]  = imm_cycle(REG_W);
        word.cycles[2]  = misc_cycle(MISC_JP_WZ);
        word.cycles[3]  = fetch_cycle();
      end
      8'h20: begin
        // Failed condition skips to the last slot
        word.num_cycles        = 3'd3;
        word.cycles[0]         = imm_cycle(REG_Z);
        word.cycles[0].misc_op = MISC_COND_CHECK;
        word.cycles[0].cond    = COND_NZ;
        word.cycles[1]         = misc_cycle(MISC_JR_Z);
        word.cycles[2]         = fetch_cycle();
        word.cycles[MAX_CYCLES_PER_INSTR-1] = fetch_cycle();
      end
      8'h18: begin
        word.num_cycles = 3'd3;
        word.cycles[0]  = imm_cycle(REG_Z);
        word.cycles[1]  = misc_cycle(MISC_JR_Z);
        word.cycles[2]  = fetch_cycle();
      end
      8'he0: begin
        word.num_cycles = 3'd3;
        word.cycles[0]  = imm_cycle(REG_Z);
        word.cycles[1]  = mem_cycle(ADDR_FF_Z, BUS_WRITE, REG_A);
        word.cycles[2]  = fetch_cycle();
      end
      8'hf0: begin
        word.num_cycles = 3'd3;
        word.cycles[0]  = imm_cycle(REG_Z);
        word.cycles[1]  = mem_cycle(ADDR_FF_Z, BUS_READ, REG_A);
        word.cycles[2]  = fetch_cycle();
      end
      default: ;
    endcase
  end

endmodule

// ==== hw/cpu_alu.sv ====
`timescale 1ns/100ps

module cpu_alu
  import cpu_pkg::*;
(
  input  alu_op_t    op,
  input  byte_t      a,
  input  byte_t      b,
  input  logic [3:0] flags_in,
  output alu_out_t   result
);

  logic [4:0] half;
  logic [8:0] full;
  byte_t      xor_val;

  // Bit 4 and bit 8 hold the carry, or the borrow for SUB
  always_comb begin
    if (op == ALU_SUB) begin
      half = {1'b0, a[3:0]} - {1'b0, b[3:0]};
      full = {1'b0, a} - {1'b0, b};
    end else begin
      half = {1'b0, a[3:0]} + {1'b0, b[3:0]};
      full = {1'b0, a} + {1'b0, b};
    end
  end

  assign xor_val = a ^ b;

  always_comb begin
    result.data  = a;
    result.flags = flags_in;
    case (op)
      ALU_ADD: begin
        result.data  = full[7:0];
        result.flags = {full[7:0] == 8'h00, 1'b0, half[4], full[8]};
      end
      ALU_SUB: begin
        result.data  = full[7:0];
        result.flags = {full[7:0] == 8'h00, 1'b1, half[4], full[8]};
      end
      ALU_XOR: begin
        result.data  = xor_val;
        result.flags = {xor_val == 8'h00, 3'b000};
      end
      ALU_MOV: result.data = b;
      default: ;
    endcase
  end

endmodule

// ==== hw/cpu_regfile.sv ====
`timescale 1ns/100ps

module cpu_regfile
  import cpu_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  reg_write_t update,
  output cpu_regs_t  regs
);

  cpu_regs_t next_regs;
  addr_t     idu_result;

  function automatic cpu_regs_t set_byte(cpu_regs_t r, reg_sel_t sel, byte_t v);
    cpu_regs_t n;
    n = r;
    case (sel)
      REG_A:   n.a = v;
      REG_F:   n.flags = {v[7:4], 4'h0};
      REG_B:   n.b = v;
      REG_C:   n.c = v;
      REG_D:   n.d = v;
      REG_E:   n.e = v;
      REG_H:   n.h = v;
      REG_L:   n.l = v;
      REG_W:   n.w = v;
      REG_Z:   n.z = v;
      REG_IR:  n.ir = v;
      default: ;
    endcase
    return n;
  endfunction

  // High page selects and NONE have no storage behind them
  function automatic cpu_regs_t set_pair(cpu_regs_t r, addr_src_t sel, addr_t v);
    cpu_regs_t n;
    n = r;
    case (sel)
      ADDR_PC: {n.pch, n.pcl} = v;
      ADDR_SP: {n.sph, n.spl} = v;
      ADDR_BC: {n.b, n.c} = v;
      ADDR_DE: {n.d, n.e} = v;
      ADDR_HL: {n.h, n.l} = v;
      ADDR_WZ: {n.w, n.z} = v;
      default: ;
    endcase
    return n;
  endfunction

  always_comb begin
    case (update.idu_op)
      IDU_INC: idu_result = get_pair(regs, update.idu_src) + 16'd1;
      IDU_DEC: idu_result = get_pair(regs, update.idu_src) - 16'd1;
      default: idu_result = get_pair(regs, update.idu_src);
    endcase
  end

  always_comb begin
    next_regs = regs;
    if (update.bus_reg != REG_NONE) begin
      next_regs = set_byte(next_regs, update.bus_reg, update.bus_data);
    end
    if (update.t4) begin
      if (update.idu_op != IDU_NONE) begin
        next_regs = set_pair(next_regs, update.idu_dst, idu_result);
      end
      if (update.alu_reg != REG_NONE) begin
        next_regs = set_byte(next_regs, update.alu_reg, update.alu_data);
        next_regs.flags = {update.alu_flags, 4'h0};
      end
      // A jump wins over any PC increment of the same cycle
      if (update.pc_load) begin
        {next_regs.pch, next_regs.pcl} = update.pc_value;
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      regs <= '0;
      {regs.sph, regs.spl} <= 16'hfffe;
    end else begin
      regs <= next_regs;
    end
  end

  a_no_load_clash: assert property (@(posedge clk) disable iff (reset)
    update.bus_reg != REG_NONE |-> update.bus_reg != update.alu_reg);

endmodule

// ==== hw/cpu_core.sv ====
`timescale 1ns/100ps

module cpu_core
  import cpu_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  output addr_t addr,
  output logic  read_en,
  output logic  write_en,
  output byte_t wdata,
  input  byte_t rdata,
  output logic  instr_boundary
);

  localparam cycle_count_t LAST_SLOT = cycle_count_t'(MAX_CYCLES_PER_INSTR - 1);

  t_phase_t      t_phase;
  cycle_count_t  cycle_count;
  control_word_t control_word;
  control_word_t next_word;
  cycle_word_t   cur;
  cpu_regs_t     regs;
  reg_write_t    update;
  alu_out_t      alu_res;
  byte_t         alu_a;
  byte_t         alu_b;
  addr_t         pc;
  logic          last_cycle;
  logic          cond_fail;

  // Flags byte holds Z in bit 7 and C in bit 4
  function automatic logic cond_met(cond_t cond, byte_t flags);
    case (cond)
      COND_NZ: return !flags[7];
      COND_Z:  return flags[7];
      COND_NC: return !flags[4];
      default: return flags[4];
    endcase
  endfunction

  assign cur        = control_word.cycles[cycle_count];
  assign pc         = {regs.pch, regs.pcl};
  assign alu_a      = get_byte(regs, cur.alu_dst);
  assign alu_b      = get_byte(regs, cur.alu_src);
  assign last_cycle = (cycle_count + 3'd1) >= control_word.num_cycles;
  assign cond_fail  = (cur.misc_op == MISC_COND_CHECK) && !cond_met(cur.cond, regs.flags);

  cpu_microcode i_microcode (
    .opcode (regs.ir),
    .word   (next_word)
  );

  cpu_alu i_alu (
    .op       (cur.alu_op),
    .a        (alu_a),
    .b        (alu_b),
    .flags_in (regs.flags[7:4]),
    .result   (alu_res)
  );

  cpu_regfile i_regfile (
    .clk    (clk),
    .reset  (reset),
    .update (update),
    .regs   (regs)
  );

  always_comb begin
    update           = '0;
    update.bus_reg   = (t_phase == T3 && cur.bus_op == BUS_READ) ? cur.bus_reg : REG_NONE;
    update.bus_data  = rdata;
    update.idu_src   = cur.addr_src;
    update.idu_dst   = (cur.idu_dst == ADDR_NONE) ? cur.addr_src : cur.idu_dst;
    update.idu_op    = cur.idu_op;
    update.alu_reg   = (cur.alu_op == ALU_NONE) ? REG_NONE : cur.alu_dst;
    update.alu_data  = alu_res.data;
    update.alu_flags = alu_res.flags;
    update.pc_load   = (cur.misc_op == MISC_JP_WZ) || (cur.misc_op == MISC_JR_Z);
    // Z holds the signed jump offset for JR
    update.pc_value  = (cur.misc_op == MISC_JP_WZ) ? {regs.w, regs.z}
                                                   : pc + {{8{regs.z[7]}}, regs.z};
    update.t4        = (t_phase == T4);
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      t_phase        <= T1;
      cycle_count    <= '0;
      control_word   <= nop_word();
      addr           <= 16'h0000;
      read_en        <= 1'b0;
      write_en       <= 1'b0;
      wdata          <= 8'h00;
      instr_boundary <= 1'b0;
    end else begin
      instr_boundary <= 1'b0;
      case (t_phase)
        T1: begin
          addr    <= get_pair(regs, cur.addr_src);
          t_phase <= T2;
        end
        T2: begin
          read_en  <= (cur.bus_op == BUS_READ);
          write_en <= (cur.bus_op == BUS_WRITE);
          if (cur.bus_op == BUS_WRITE) begin
            wdata <= get_byte(regs, cur.bus_reg);
          end
          t_phase <= T3;
        end
        T3: t_phase <= T4;
        T4: begin
          read_en  <= 1'b0;
          write_en <= 1'b0;
          if (cond_fail) begin
            cycle_count <= LAST_SLOT;
          end else if (last_cycle) begin
            // IR already holds the opcode fetched in T3 of this cycle
            cycle_count    <= '0;
            control_word   <= next_word;
            instr_boundary <= 1'b1;
          end else begin
            cycle_count <= cycle_count + 3'd1;
          end
          t_phase <= T1;
        end
        default: t_phase <= T1;
      endcase
    end
  end

  a_strobe_excl: assert property (@(posedge clk) disable iff (reset)
    !(read_en && write_en));

  a_strobe_phase: assert property (@(posedge clk) disable iff (reset)
    (t_phase == T1 || t_phase == T2) |-> !read_en && !write_en);

endmodule

// ==== hw/hram_unit.sv ====
`timescale 1ns/100ps

module hram_unit
  import cpu_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  addr_t core_addr,
  input  logic  core_read_en,
  input  logic  core_write_en,
  input  byte_t core_wdata,
  output byte_t core_rdata,
  output logic  ext_read_en,
  output logic  ext_write_en,
  input  byte_t ext_rdata
);

  byte_t      mem [0:126];
  logic       hit;
  logic [6:0] idx;

  // FF80 to FFFE, FFFF stays outside
  assign hit = (core_addr >= 16'hff80) && (core_addr <= 16'hfffe);
  assign idx = core_addr[6:0];

  always_ff @(posedge clk) begin
    if (hit && core_write_en && !reset) begin
      mem[idx] <= core_wdata;
    end
  end

  assign ext_read_en  = core_read_en && !hit;
  assign ext_write_en = core_write_en && !hit;
  assign core_rdata   = hit ? mem[idx] : ext_rdata;

endmodule

// ==== hw/gb_cpu_top.sv ====
`timescale 1ns/100ps

module gb_cpu_top
  import cpu_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  output addr_t addr,
  output logic  read_en,
  output logic  write_en,
  output byte_t wdata,
  input  byte_t rdata,
  output logic  instr_boundary
);

  logic  core_read_en;
  logic  core_write_en;
  byte_t core_rdata;

  cpu_core i_core (
    .clk            (clk),
    .reset          (reset),
    .addr           (addr),
    .read_en        (core_read_en),
    .write_en       (core_write_en),
    .wdata          (wdata),
    .rdata          (core_rdata),
    .instr_boundary (instr_boundary)
  );

  // Address and write data go out unchanged, strobes only for non-HRAM accesses
  hram_unit i_hram (
    .clk           (clk),
    .reset         (reset),
    .core_addr     (addr),
    .core_read_en  (core_read_en),
    .core_write_en (core_write_en),
    .core_wdata    (wdata),
    .core_rdata    (core_rdata),
    .ext_read_en   (read_en),
    .ext_write_en  (write_en),
    .ext_rdata     (rdata)
  );

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock (
  output logic clk,
  output logic reset
);

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Reset spans two rising edges and drops just after the second
  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule

// ==== bench/tb_memory.sv ====
`timescale 1ns/100ps

module tb_memory
  import cpu_pkg::*;
(
  input  logic  clk,
  input  addr_t addr,
  input  logic  write_en,
  input  byte_t wdata,
  output byte_t rdata
);

  byte_t mem [0:65535];

  // Background bytes for locations the program leaves alone
  task automatic fill_background();
    addr_t a;
    for (int i = 0; i < 65536; i++) begin
      a = addr_t'(i);
      mem[a] <= a[15:8] ^ a[7:0] ^ 8'h3c;
    end
  endtask

  task automatic load_byte(addr_t a, byte_t d);
    mem[a] <= d;
  endtask

  assign rdata = mem[addr];

  // Stores land in the array so a later read sees them
  always @(posedge clk) begin
    if (write_en) begin
      mem[addr] <= wdata;
    end
  end

endmodule

// ==== bench/tb_cpu.sv ====
`timescale 1ns/100ps

module tb_cpu
  import cpu_pkg::*;
();

  localparam int MAX_EVENTS   = 256;
  localparam int ROUNDS       = 12;
  localparam int RESET_LIMIT  = 10;
  localparam int DONE_TIMEOUT = 5000;

  logic  clk;
  logic  reset;
  addr_t addr;
  logic  read_en;
  logic  write_en;
  byte_t wdata;
  byte_t rdata;
  logic  instr_boundary;

  // Expected boundaries in execution order and expected external writes
  addr_t exp_fetch  [0:MAX_EVENTS-1];
  int    exp_cycles [0:MAX_EVENTS-1];
  addr_t exp_waddr  [0:MAX_EVENTS-1];
  byte_t exp_wdata  [0:MAX_EVENTS-1];
  int    n_bounds;
  int    n_writes;

  logic [31:0] seed;
  addr_t       pc_gen;
  int          prev_cycles;
  int          mismatches;
  int          failures;

  // Bus monitor state
  logic  read_en_q;
  logic  write_en_q;
  logic  read_rise;
  logic  write_rise;
  logic  bound_checked;
  logic  write_checked;
  addr_t last_read;
  int    bound_idx;
  int    write_idx;
  int    clks_since;
  int    reads_seen;
  addr_t fetch_exp;
  int    cycles_exp;
  addr_t waddr_exp;
  byte_t wdata_exp;

  tb_clock i_clock (
    .clk   (clk),
    .reset (reset)
  );

  tb_memory i_mem (
    .clk      (clk),
    .addr     (addr),
    .write_en (write_en),
    .wdata    (wdata),
    .rdata    (rdata)
  );

  gb_cpu_top i_dut (
    .clk            (clk),
    .reset          (reset),
    .addr           (addr),
    .read_en        (read_en),
    .write_en       (write_en),
    .wdata          (wdata),
    .rdata          (rdata),
    .instr_boundary (instr_boundary)
  );

  function automatic logic [31:0] next_random(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic put(byte_t b);
    i_mem.load_byte(pc_gen, b);
    pc_gen = pc_gen + 16'd1;
  endtask

  // Boundary j expects the fetch of instruction j after instruction j-1 ran
  task automatic log_exec(int cycles);
    exp_fetch[n_bounds]  = pc_gen;
    exp_cycles[n_bounds] = prev_cycles;
    prev_cycles = cycles;
    n_bounds++;
  endtask

  task automatic exec_op(byte_t op, int cycles);
    log_exec(cycles);
    put(op);
  endtask

  task automatic exec_imm(byte_t op, byte_t imm, int cycles);
    log_exec(cycles);
    put(op);
    put(imm);
  endtask

  task automatic expect_write(addr_t a, byte_t d);
    exp_waddr[n_writes] = a;
    exp_wdata[n_writes] = d;
    n_writes++;
  endtask

  // Assembles the program and runs the reference model alongside
  task automatic build_program();
    byte_t a_val;
    byte_t b_val;
    byte_t res;
    byte_t stored;
    addr_t hl;
    addr_t loop_pc;
    int    op;
    int    r;
    pc_gen = 16'h0000;
    prev_cycles = 1;
    hl = 16'hc000;
    exec_imm(8'h26, 8'hc0, 2);
    exec_imm(8'h2e, 8'h00, 2);
    for (r = 0; r < ROUNDS; r++) begin
      seed = next_random(seed);
      a_val = seed[7:0];
      b_val = seed[15:8];
      // Equal operands make SUB give zero now and then
      if (seed[18:16] == 3'd0) begin
        b_val = a_val;
      end
      op = int'(seed[27:24]) % 3;
      exec_imm(8'h3e, a_val, 2);
      exec_imm(8'h06, b_val, 2);
      case (op)
        0: begin
          exec_op(8'h80, 1);
          res = a_val + b_val;
        end
        1: begin
          exec_op(8'h90, 1);
          res = a_val - b_val;
        end
        default: begin
          exec_op(8'haf, 1);
          res = 8'h00;
        end
      endcase
      // JR NZ over a two-byte LD C,d8
      exec_imm(8'h20, 8'h02, (res == 8'h00) ? 2 : 3);
      if (res == 8'h00) begin
        exec_imm(8'h0e, seed[31:24], 2);
      end else begin
        put(8'h0e);
        put(seed[31:24]);
      end
      exec_op(8'h22, 2);
      expect_write(hl, res);
      hl = hl + 16'd1;
    end
    // Round trip through high RAM at FF90
    seed = next_random(seed);
    stored = seed[7:0];
    exec_imm(8'h3e, stored, 2);
    exec_imm(8'he0, 8'h90, 3);
    exec_imm(8'h3e, ~stored, 2);
    exec_imm(8'hf0, 8'h90, 3);
    exec_op(8'h22, 2);
    expect_write(hl, stored);
    hl = hl + 16'd1;
    log_exec(4);
    put(8'hc3);
    put(8'h00);
    put(8'h02);
    pc_gen = 16'h0200;
    exec_op(8'h00, 1);
    exec_op(8'h23, 2);
    hl = hl + 16'd1;
    exec_op(8'h77, 2);
    expect_write(hl, stored);
    // Self loop, two passes checked
    loop_pc = pc_gen;
    exec_imm(8'h18, 8'hfe, 3);
    pc_gen = loop_pc;
    log_exec(3);
  endtask

  assign read_rise     = read_en && !read_en_q;
  assign write_rise    = write_en && !write_en_q;
  assign bound_checked = instr_boundary && (bound_idx < n_bounds);
  assign write_checked = write_rise && (write_idx < n_writes);
  assign fetch_exp     = (bound_idx < n_bounds) ? exp_fetch[bound_idx] : 16'h0000;
  assign cycles_exp    = (bound_idx < n_bounds) ? exp_cycles[bound_idx] : 0;
  assign waddr_exp     = (write_idx < n_writes) ? exp_waddr[write_idx] : 16'h0000;
  assign wdata_exp     = (write_idx < n_writes) ? exp_wdata[write_idx] : 8'h00;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      read_en_q  <= 1'b0;
      write_en_q <= 1'b0;
      last_read  <= 16'h0000;
      bound_idx  <= 0;
      write_idx  <= 0;
      clks_since <= 0;
      reads_seen <= 0;
    end else begin
      read_en_q  <= read_en;
      write_en_q <= write_en;
      clks_since <= instr_boundary ? 1 : clks_since + 1;
      if (instr_boundary) begin
        bound_idx <= bound_idx + 1;
      end
      if (read_rise) begin
        last_read  <= addr;
        reads_seen <= reads_seen + 1;
      end
      if (write_rise) begin
        write_idx <= write_idx + 1;
      end
    end
  end

  a_reset_idle: assert property (@(posedge clk)
    $fell(reset) |-> !read_en && !write_en && !instr_boundary)
    else begin
      failures++;
      $display("%0t: strobes or instr_boundary not low after reset", $time);
    end

  a_first_read: assert property (@(posedge clk) disable iff (reset)
    read_rise && reads_seen == 0 |-> addr == 16'h0000)
    else begin
      mismatches++;
      $display("Mismatch at %0t: addr expected 0000 got %h", $time, $sampled(addr));
    end

  a_read_width: assert property (@(posedge clk) disable iff (reset)
    $rose(read_en) |=> read_en ##1 !read_en)
    else begin
      failures++;
      $display("%0t: read_en pulse is not exactly 2 clocks long", $time);
    end

  a_write_width: assert property (@(posedge clk) disable iff (reset)
    $rose(write_en) |=> write_en ##1 !write_en)
    else begin
      failures++;
      $display("%0t: write_en pulse is not exactly 2 clocks long", $time);
    end

  a_hram_internal: assert property (@(posedge clk) disable iff (reset)
    (read_en || write_en) |-> !(addr >= 16'hff80 && addr <= 16'hfffe))
    else begin
      failures++;
      $display("%0t: external strobe seen for high-RAM address %h", $time, $sampled(addr));
    end

  a_fetch_addr: assert property (@(posedge clk) disable iff (reset)
    bound_checked |-> last_read == fetch_exp)
    else begin
      mismatches++;
      $display("Mismatch at %0t: fetch addr expected %h got %h", $time,
               $sampled(fetch_exp), $sampled(last_read));
    end

  a_instr_len: assert property (@(posedge clk) disable iff (reset)
    bound_checked |-> clks_since == 4 * cycles_exp)
    else begin
      mismatches++;
      $display("Mismatch at %0t: instr_boundary spacing expected %0d got %0d", $time,
               4 * $sampled(cycles_exp), $sampled(clks_since));
    end

  a_write_known: assert property (@(posedge clk) disable iff (reset)
    write_rise |-> write_idx < n_writes)
    else begin
      failures++;
      $display("%0t: unexpected external write at %h", $time, $sampled(addr));
    end

  a_write_addr: assert property (@(posedge clk) disable iff (reset)
    write_checked |-> addr == waddr_exp)
    else begin
      mismatches++;
      $display("Mismatch at %0t: addr expected %h got %h", $time,
               $sampled(waddr_exp), $sampled(addr));
    end

  a_write_data: assert property (@(posedge clk) disable iff (reset)
    write_checked |-> wdata == wdata_exp)
    else begin
      mismatches++;
      $display("Mismatch at %0t: wdata expected %h got %h", $time,
               $sampled(wdata_exp), $sampled(wdata));
    end

  initial begin
    int wait_clks;
    seed       = 32'hee5a;
    mismatches = 0;
    failures   = 0;
    n_bounds   = 0;
    n_writes   = 0;
    i_mem.fill_background();
    build_program();
    wait_clks = 0;
    while (reset && wait_clks < RESET_LIMIT) begin
      @(posedge clk);
      wait_clks++;
    end
    if (reset) begin
      failures++;
      $display("Reset was never released");
    end
    wait_clks = 0;
    while ((bound_idx < n_bounds || write_idx < n_writes) && wait_clks < DONE_TIMEOUT) begin
      @(posedge clk);
      wait_clks++;
    end
    if (wait_clks >= DONE_TIMEOUT) begin
      failures++;
      $display("Timeout: %0d of %0d boundaries and %0d of %0d writes seen",
               bound_idx, n_bounds, write_idx, n_writes);
    end
    // A few more loop passes so late strobes still meet the assertions
    repeat (8) @(posedge clk);
    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== all.f ====
hw/cpu_pkg.sv
hw/cpu_microcode.sv
hw/cpu_alu.sv
hw/cpu_regfile.sv
hw/cpu_core.sv
hw/hram_unit.sv
hw/gb_cpu_top.sv
bench/tb_clock.sv
bench/tb_memory.sv
bench/tb_cpu.sv
